//--- Bender.yml
package:
  name: dual_dcache

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/dcache_pkg.sv
      - rtl/mem_req_if.sv
      - rtl/fa_line_array.sv
      - rtl/dcache.sv
      - rtl/mem_arbiter.sv
      - rtl/backing_memory.sv
      - rtl/dual_dcache_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_dual_dcache.sv

//--- flist.f
+incdir+rtl
rtl/dcache_pkg.sv
rtl/mem_req_if.sv
rtl/fa_line_array.sv
rtl/dcache.sv
rtl/mem_arbiter.sv
rtl/backing_memory.sv
rtl/dual_dcache_top.sv
test/tb_dual_dcache.sv

//--- rtl/backing_memory.sv
`default_nettype none

`include "dcache_consts.svh"

module backing_memory
  import dcache_pkg::*;
(
  input  logic clk,
  input  logic arst_n,
  mem_req_if.responder bus
);

  localparam int MEM_BYTES = 2 ** `DC_ADDR_W;
  localparam int CNT_W     = $clog2(`DC_MEM_LATENCY + 1);

  logic [7:0]  mem_q [MEM_BYTES];
  mem_state_e  state_q;
  logic [CNT_W-1:0] cnt_q;
  logic        lat_done;

  // latched transfer
  logic  store_q;
  logic  word_q;
  addr_t addr_q;
  word_t wdata_q;
  addr_t line_base;

  assign line_base  = {addr_q[`DC_ADDR_W-1:`DC_OFFSET_W], `DC_OFFSET_W'(0)};
  assign lat_done   = (state_q == MEM_BUSY) && (cnt_q == CNT_W'(`DC_MEM_LATENCY - 1));
  assign bus.ready      = (state_q == MEM_IDLE);
  assign bus.fill_valid = (state_q == MEM_DONE);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= MEM_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        MEM_IDLE: begin
          if (bus.valid) begin
            state_q <= MEM_BUSY;
            cnt_q   <= '0;
          end
        end
        MEM_BUSY: begin
          if (lat_done) begin
            state_q <= MEM_DONE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= MEM_IDLE;
      endcase
    end
  end

  // content at reset is the low address byte xor 5A
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < MEM_BYTES; i++) begin
        mem_q[i] <= 8'(i) ^ 8'h5A;
      end
    end else if (lat_done && store_q) begin
      if (word_q) begin
        for (int k = 0; k < `DC_DATA_W / 8; k++) begin
          mem_q[addr_q | addr_t'(k)] <= wdata_q[k*8 +: 8];
        end
      end else begin
        mem_q[addr_q] <= wdata_q[7:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus.valid && bus.ready) begin
      store_q <= bus.store;
      word_q  <= bus.word;
      addr_q  <= bus.addr;
      wdata_q <= bus.wdata;
    end
    // little-endian line assembly
    if (lat_done && !store_q) begin
      for (int b = 0; b < `DC_LINE_BYTES; b++) begin
        bus.fill_line[b*8 +: 8] <= mem_q[line_base | addr_t'(b)];
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/dcache.sv
`default_nettype none

`include "dcache_consts.svh"

module dcache
  import dcache_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  req_valid,
  output logic  req_ready,
  input  logic  store,
  input  logic  word,
  input  addr_t addr,
  input  word_t wdata,
  output logic  resp_valid,
  output logic  resp_hit,
  output word_t rdata,
  mem_req_if.requester mem
);

  dcache_state_e state_q;
  dcache_state_e state_d;

  // registered request
  logic  store_q;
  logic  word_q;
  addr_t addr_q;
  word_t wdata_q;

  tag_t  req_tag;
  logic  hit;
  line_t hit_line;
  logic  need_mem;
  logic  fill_done;

  // word at addr, or zero-extended byte
  function automatic word_t extract_data(line_t line, addr_t a, logic is_word);
    word_t      w;
    logic [7:0] b;
    w = line[a[`DC_OFFSET_W-1:2]*`DC_DATA_W +: `DC_DATA_W];
    b = w[a[1:0]*8 +: 8];
    return is_word ? w : word_t'(b);
  endfunction

  assign req_tag   = addr_q[`DC_ADDR_W-1:`DC_OFFSET_W];
  assign need_mem  = store_q | ~hit;
  assign fill_done = (state_q == MEM_WAIT) && mem.fill_valid;

  fa_line_array u_line_array (
    .clk        (clk),
    .arst_n     (arst_n),
    .lookup_tag (req_tag),
    .fill_en    (fill_done && !store_q),
    .fill_tag   (req_tag),
    .fill_line  (mem.fill_line),
    .inval_en   (fill_done && store_q),
    .inval_tag  (req_tag),
    .hit        (hit),
    .hit_line   (hit_line)
  );

  assign req_ready  = (state_q == IDLE);
  assign resp_valid = (state_q == RESPOND);

  // memory request goes out already in LOOKUP on a miss or store
  assign mem.valid = ((state_q == LOOKUP) && need_mem) || (state_q == MEM_REQ);
  assign mem.store = store_q;
  assign mem.word  = word_q;
  assign mem.addr  = addr_q;
  assign mem.wdata = wdata_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:     if (req_valid) state_d = LOOKUP;
      LOOKUP: begin
        if (!need_mem) begin
          state_d = RESPOND;
        end else if (mem.ready) begin
          state_d = MEM_WAIT;
        end else begin
          state_d = MEM_REQ;
        end
      end
      MEM_REQ:  if (mem.ready) state_d = MEM_WAIT;
      MEM_WAIT: if (mem.fill_valid) state_d = RESPOND;
      RESPOND:  state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q  <= IDLE;
      resp_hit <= 1'b0;
    end else begin
      state_q <= state_d;
      if ((state_q == LOOKUP) && !need_mem) begin
        resp_hit <= 1'b1;
      end else if (fill_done) begin
        resp_hit <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      store_q <= store;
      word_q  <= word;
      addr_q  <= addr;
      wdata_q <= wdata;
    end
    if ((state_q == LOOKUP) && !need_mem) begin
      rdata <= extract_data(hit_line, addr_q, word_q);
    end else if (fill_done) begin
      // stores answer with zero data
      rdata <= store_q ? '0 : extract_data(mem.fill_line, addr_q, word_q);
    end
  end

endmodule

`default_nettype wire

//--- rtl/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// byte address width
`define DC_ADDR_W 12

// load/store word width
`define DC_DATA_W 32

// one cache line
`define DC_LINE_W 128
`define DC_LINE_BYTES 16

// byte offset inside a line
`define DC_OFFSET_W 4

// lines per cache
`define DC_NUM_LINES 4

// memory acceptance to fill_valid
`define DC_MEM_LATENCY 4

`endif

//--- rtl/dcache_pkg.sv
`default_nettype none

`include "dcache_consts.svh"

package dcache_pkg;

  // byte address and data widths
  typedef logic [`DC_ADDR_W-1:0] addr_t;
  typedef logic [`DC_DATA_W-1:0] word_t;
  typedef logic [`DC_LINE_W-1:0] line_t;

  // line address is the byte address without the offset
  typedef logic [`DC_ADDR_W-`DC_OFFSET_W-1:0] tag_t;

  // slot index inside one cache
  typedef logic [1:0] way_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    MEM_REQ,
    MEM_WAIT,
    RESPOND
  } dcache_state_e;

  typedef enum logic [1:0] {
    MEM_IDLE,
    MEM_BUSY,
    MEM_DONE
  } mem_state_e;

endpackage

`default_nettype wire

//--- rtl/dual_dcache_top.sv
`default_nettype none

module dual_dcache_top
  import dcache_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,

  input  logic  req_valid_1,
  output logic  req_ready_1,
  input  logic  store_1,
  input  logic  word_1,
  input  addr_t addr_1,
  input  word_t wdata_1,
  output logic  resp_valid_1,
  output logic  resp_hit_1,
  output word_t rdata_1,

  input  logic  req_valid_2,
  output logic  req_ready_2,
  input  logic  store_2,
  input  logic  word_2,
  input  addr_t addr_2,
  input  word_t wdata_2,
  output logic  resp_valid_2,
  output logic  resp_hit_2,
  output word_t rdata_2
);

  mem_req_if cache_1_mem ();
  mem_req_if cache_2_mem ();
  mem_req_if mem_bus ();

  dcache u_dcache_1 (
    .clk        (clk),
    .arst_n     (arst_n),
    .req_valid  (req_valid_1),
    .req_ready  (req_ready_1),
    .store      (store_1),
    .word       (word_1),
    .addr       (addr_1),
    .wdata      (wdata_1),
    .resp_valid (resp_valid_1),
    .resp_hit   (resp_hit_1),
    .rdata      (rdata_1),
    .mem        (cache_1_mem.requester)
  );

  dcache u_dcache_2 (
    .clk        (clk),
    .arst_n     (arst_n),
    .req_valid  (req_valid_2),
    .req_ready  (req_ready_2),
    .store      (store_2),
    .word       (word_2),
    .addr       (addr_2),
    .wdata      (wdata_2),
    .resp_valid (resp_valid_2),
    .resp_hit   (resp_hit_2),
    .rdata      (rdata_2),
    .mem        (cache_2_mem.requester)
  );

  mem_arbiter u_mem_arbiter (
    .clk    (clk),
    .arst_n (arst_n),
    .req_1  (cache_1_mem.responder),
    .req_2  (cache_2_mem.responder),
    .mem    (mem_bus.requester)
  );

  backing_memory u_backing_memory (
    .clk    (clk),
    .arst_n (arst_n),
    .bus    (mem_bus.responder)
  );

endmodule

`default_nettype wire

//--- rtl/fa_line_array.sv
`default_nettype none

`include "dcache_consts.svh"

module fa_line_array
  import dcache_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  tag_t  lookup_tag,
  input  logic  fill_en,
  input  tag_t  fill_tag,
  input  line_t fill_line,
  input  logic  inval_en,
  input  tag_t  inval_tag,
  output logic  hit,
  output line_t hit_line
);

  logic [`DC_NUM_LINES-1:0] valid_q;
  tag_t                     tag_q  [`DC_NUM_LINES];
  line_t                    line_q [`DC_NUM_LINES];
  way_t                     rr_ptr;

  // parallel tag compare over all slots
  always_comb begin
    hit      = 1'b0;
    hit_line = '0;
    for (int i = 0; i < `DC_NUM_LINES; i++) begin
      if (valid_q[i] && (tag_q[i] == lookup_tag)) begin
        hit      = 1'b1;
        hit_line = line_q[i];
      end
    end
  end

  // valid bits and replacement pointer
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
      rr_ptr  <= '0;
    end else begin
      if (inval_en) begin
        for (int i = 0; i < `DC_NUM_LINES; i++) begin
          if (tag_q[i] == inval_tag) begin
            valid_q[i] <= 1'b0;
          end
        end
      end
      // a fill overrides an invalidate of the same slot
      if (fill_en) begin
        valid_q[rr_ptr] <= 1'b1;
        if (rr_ptr == way_t'(`DC_NUM_LINES - 1)) begin
          rr_ptr <= '0;
        end else begin
          rr_ptr <= rr_ptr + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fill_en) begin
      tag_q[rr_ptr]  <= fill_tag;
      line_q[rr_ptr] <= fill_line;
    end
  end

endmodule

`default_nettype wire

//--- rtl/mem_arbiter.sv
`default_nettype none

module mem_arbiter
  import dcache_pkg::*;
(
  input  logic clk,
  input  logic arst_n,
  mem_req_if.responder req_1,
  mem_req_if.responder req_2,
  mem_req_if.requester mem
);

  // 0 = port 1, 1 = port 2
  logic last_grant;
  logic busy;
  logic sel;

  // while busy the last grant is the owner of the transfer
  always_comb begin
    if (busy) begin
      sel = last_grant;
    end else if (req_1.valid && req_2.valid) begin
      sel = ~last_grant;
    end else begin
      sel = req_2.valid;
    end
  end

  assign mem.valid = !busy && (sel ? req_2.valid : req_1.valid);
  assign mem.store = sel ? req_2.store : req_1.store;
  assign mem.word  = sel ? req_2.word  : req_1.word;
  assign mem.addr  = sel ? req_2.addr  : req_1.addr;
  assign mem.wdata = sel ? req_2.wdata : req_1.wdata;

  assign req_1.ready = !busy && !sel && mem.ready;
  assign req_2.ready = !busy && sel && mem.ready;

  // fill goes back only to the owner
  assign req_1.fill_valid = busy && !last_grant && mem.fill_valid;
  assign req_2.fill_valid = busy && last_grant && mem.fill_valid;
  assign req_1.fill_line  = last_grant ? '0 : mem.fill_line;
  assign req_2.fill_line  = last_grant ? mem.fill_line : '0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy       <= 1'b0;
      last_grant <= 1'b1;
    end else if (mem.valid && mem.ready) begin
      busy       <= 1'b1;
      last_grant <= sel;
    end else if (mem.fill_valid) begin
      busy <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- rtl/mem_req_if.sv
`default_nettype none

interface mem_req_if
  import dcache_pkg::*;
();

  // request channel
  logic  valid;
  logic  ready;
  logic  store;
  logic  word;
  addr_t addr;
  word_t wdata;

  // one-cycle fill or store acknowledge
  logic  fill_valid;
  line_t fill_line;

  modport requester (
    output valid, store, word, addr, wdata,
    input  ready, fill_valid, fill_line
  );

  modport responder (
    input  valid, store, word, addr, wdata,
    output ready, fill_valid, fill_line
  );

endinterface

`default_nettype wire

//--- test/tb_dual_dcache.sv
`default_nettype none

`include "dcache_consts.svh"

module tb_dual_dcache
  import dcache_pkg::*;
();

  localparam int TIMEOUT = 200;

  logic  clk;
  logic  arst_n;
  logic  req_valid_1, req_ready_1, store_1, word_1, resp_valid_1, resp_hit_1;
  logic  req_valid_2, req_ready_2, store_2, word_2, resp_valid_2, resp_hit_2;
  addr_t addr_1, addr_2;
  word_t wdata_1, wdata_2, rdata_1, rdata_2;

  // stimulus table with one entry per row
  int    row_port  [$];
  bit    row_pair  [$];
  logic  row_store [$];
  logic  row_word  [$];
  addr_t row_addr  [$];
  word_t row_wdata [$];
  string row_name  [$];

  // reference model of memory and of the tags of each cache
  logic [7:0] model_mem [2**`DC_ADDR_W];
  tag_t       model_tag [2][`DC_NUM_LINES];
  bit         model_valid [2][`DC_NUM_LINES];
  int         model_ptr [2];

  int error_count;
  int timeout_count;
  bit aborted;
  int seed;
  int idx;

  dual_dcache_top DUT (.*);

  always #10 clk = ~clk;

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic check_value(input string name, input string field, input word_t exp,
                             input word_t act);
    if (exp !== act) begin
      error_count++;
      $display("[ERROR] %s %s: expected %h, actual %h", name, field, exp, act);
    end
  endtask

  task automatic add_row(input int p, input bit pair, input logic st, input logic wd,
                         input addr_t a, input word_t d, input string name);
    row_port.push_back(p);
    row_pair.push_back(pair);
    row_store.push_back(st);
    row_word.push_back(wd);
    row_addr.push_back(a);
    row_wdata.push_back(d);
    row_name.push_back(name);
  endtask

  task automatic drive_port(input int p, input logic v, input logic st, input logic wd,
                            input addr_t a, input word_t d);
    if (p == 1) begin
      req_valid_1 = v;
      store_1     = st;
      word_1      = wd;
      addr_1      = a;
      wdata_1     = d;
    end else begin
      req_valid_2 = v;
      store_2     = st;
      word_2      = wd;
      addr_2      = a;
      wdata_2     = d;
    end
  endtask

  function automatic logic ready_of(input int p);
    return (p == 1) ? req_ready_1 : req_ready_2;
  endfunction

  function automatic logic resp_of(input int p);
    return (p == 1) ? resp_valid_1 : resp_valid_2;
  endfunction

  // expected response while the model is updated for the access
  task automatic model_access(input int p, input logic st, input logic wd, input addr_t a,
                              input word_t d, output logic hit, output word_t data);
    tag_t t;
    int   s;
    t    = a[`DC_ADDR_W-1:`DC_OFFSET_W];
    s    = p - 1;
    hit  = 1'b0;
    data = '0;
    if (st) begin
      for (int k = 0; k < (wd ? 4 : 1); k++) begin
        model_mem[a + k] = d[k*8 +: 8];
      end
      // only the storing port drops its copy
      for (int i = 0; i < `DC_NUM_LINES; i++) begin
        if (model_tag[s][i] == t) model_valid[s][i] = 1'b0;
      end
    end else begin
      for (int i = 0; i < `DC_NUM_LINES; i++) begin
        if (model_valid[s][i] && model_tag[s][i] == t) hit = 1'b1;
      end
      data = wd ? {model_mem[a + 3], model_mem[a + 2], model_mem[a + 1], model_mem[a]}
                : {24'h0, model_mem[a]};
      if (!hit) begin
        model_tag[s][model_ptr[s]]   = t;
        model_valid[s][model_ptr[s]] = 1'b1;
        model_ptr[s] = (model_ptr[s] + 1) % `DC_NUM_LINES;
      end
    end
  endtask

  // issue one row, or two rows on different ports in the same cycle
  task automatic run_rows(input int first, input int count);
    logic  exp_hit [2];
    word_t exp_data [2];
    bit    done [2];
    int    remaining;
    int    cyc;
    int    p;
    cyc = 0;
    while (!(ready_of(row_port[first]) && (count < 2 || ready_of(row_port[first + 1])))
           && cyc < TIMEOUT) begin
      step();
      cyc++;
    end
    if (cyc >= TIMEOUT) begin
      timeout_count++;
      aborted = 1'b1;
      $display("timeout: request ready never came for row %s", row_name[first]);
      return;
    end
    for (int k = 0; k < count; k++) begin
      model_access(row_port[first + k], row_store[first + k], row_word[first + k],
                   row_addr[first + k], row_wdata[first + k], exp_hit[k], exp_data[k]);
      drive_port(row_port[first + k], 1'b1, row_store[first + k], row_word[first + k],
                 row_addr[first + k], row_wdata[first + k]);
      done[k] = 1'b0;
    end
    step();
    for (int k = 0; k < count; k++) begin
      drive_port(row_port[first + k], 1'b0, 1'b0, 1'b0, '0, '0);
    end
    remaining = count;
    cyc = 0;
    while (remaining > 0 && cyc < TIMEOUT) begin
      step();
      cyc++;
      for (int k = 0; k < count; k++) begin
        p = row_port[first + k];
        if (!done[k] && resp_of(p)) begin
          done[k] = 1'b1;
          remaining--;
          check_value(row_name[first + k], "resp_hit", word_t'(exp_hit[k]),
                      word_t'((p == 1) ? resp_hit_1 : resp_hit_2));
          check_value(row_name[first + k], "rdata", exp_data[k],
                      (p == 1) ? rdata_1 : rdata_2);
          if (exp_hit[k]) begin
            check_value(row_name[first + k], "hit latency", 1, cyc);
          end
        end
      end
    end
    if (remaining > 0) begin
      timeout_count++;
      aborted = 1'b1;
      $display("timeout: no response came for row %s", row_name[first]);
    end
  endtask

  task automatic add_random_rows(input int n);
    int    r;
    int    p;
    addr_t a;
    for (int i = 0; i < n; i++) begin
      r = $random(seed);
      p = r[0] ? 2 : 1;
      // a small window per port so hits and evictions both happen
      a = ((p == 1) ? 12'h700 : 12'hF00) + addr_t'(r[10:4]);
      if (r[3]) a[1:0] = 2'b00;
      add_row(p, 1'b0, r[2:1] == 2'b00, r[3], a, $random(seed), $sformatf("random_%0d", i));
    end
  endtask

  initial begin
    clk           = 1'b0;
    arst_n        = 1'b0;
    error_count   = 0;
    timeout_count = 0;
    aborted       = 1'b0;
    seed          = 16;
    drive_port(1, 1'b0, 1'b0, 1'b0, '0, '0);
    drive_port(2, 1'b0, 1'b0, 1'b0, '0, '0);
    for (int a = 0; a < 2**`DC_ADDR_W; a++) begin
      model_mem[a] = 8'(a) ^ 8'h5A;
    end
    for (int s = 0; s < 2; s++) begin
      model_ptr[s] = 0;
      for (int i = 0; i < `DC_NUM_LINES; i++) begin
        model_valid[s][i] = 1'b0;
        model_tag[s][i]   = '0;
      end
    end

    // port 1 stays below 0x800, port 2 above
    add_row(1, 0, 0, 1, 12'h100, 0, "word_miss");
    add_row(1, 0, 0, 1, 12'h108, 0, "same_line_hit");
    add_row(1, 0, 0, 0, 12'h104, 0, "byte_0");
    add_row(1, 0, 0, 0, 12'h105, 0, "byte_1");
    add_row(1, 0, 0, 0, 12'h106, 0, "byte_2");
    add_row(1, 0, 0, 0, 12'h107, 0, "byte_3");
    add_row(1, 0, 0, 1, 12'h200, 0, "prefill_word_line");
    add_row(1, 0, 0, 1, 12'h310, 0, "prefill_byte_line");
    add_row(1, 0, 1, 1, 12'h204, 32'hDEADBEEF, "store_word");
    add_row(1, 0, 1, 0, 12'h31A, 32'h000000C3, "store_byte");
    add_row(1, 0, 0, 1, 12'h204, 0, "load_stored_word");
    add_row(1, 0, 0, 0, 12'h31A, 0, "load_stored_byte");
    add_row(1, 0, 0, 1, 12'h318, 0, "untouched_bytes");
    add_row(1, 0, 0, 1, 12'h200, 0, "untouched_word");
    for (int i = 0; i < 5; i++) begin
      add_row(1, 0, 0, 1, 12'h400 + addr_t'(i * 16), 0, $sformatf("evict_fill_%0d", i));
    end
    add_row(1, 0, 0, 1, 12'h400, 0, "evicted_reload");
    add_row(1, 0, 0, 1, 12'h440, 0, "kept_440");
    add_row(1, 0, 0, 1, 12'h430, 0, "kept_430");
    add_row(1, 0, 0, 1, 12'h420, 0, "kept_420");
    add_row(1, 1, 0, 1, 12'h500, 0, "pair_miss_1");
    add_row(2, 0, 0, 1, 12'h900, 0, "pair_miss_2");
    add_row(1, 1, 0, 1, 12'h504, 0, "pair_hit_1");
    add_row(2, 0, 0, 1, 12'hD04, 0, "pair_other_2");
    add_row(1, 1, 1, 1, 12'h600, 32'h12345678, "pair_store_1");
    add_row(2, 0, 1, 0, 12'hA01, 32'h000000A5, "pair_store_2");
    add_random_rows(40);

    repeat (2) @(posedge clk);
    #2;
    arst_n = 1'b1;
    check_value("reset", "req_ready_1", 1, req_ready_1);
    check_value("reset", "req_ready_2", 1, req_ready_2);
    check_value("reset", "resp_valid", 0, resp_valid_1 | resp_valid_2);

    idx = 0;
    while (idx < row_port.size() && !aborted) begin
      if (row_pair[idx] && idx + 1 < row_port.size()) begin
        run_rows(idx, 2);
        idx += 2;
      end else begin
        run_rows(idx, 1);
        idx++;
      end
    end

    $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
